// File: Makefile
# Verilator build and run of the invaders testbench

TOP := invaders_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f

# Exit status is nonzero when the testbench stops on $$fatal
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: common/invaders_pkg.sv
`default_nettype none

package invaders_pkg;

  // -------------------------------------------------------------------------
  // 640x480 VGA timing, one pixel per clock
  // -------------------------------------------------------------------------
  localparam int H_ACTIVE = 640;
  localparam int H_FRONT  = 16;
  localparam int H_SYNC   = 96;
  localparam int H_BACK   = 48;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800
  localparam int V_ACTIVE = 480;
  localparam int V_FRONT  = 10;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 33;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525

  // Alien grid geometry
  localparam int NUM_ROWS      = 3;
  localparam int NUM_COLS      = 6;
  localparam int ALIEN_W       = 24;
  localparam int ALIEN_H       = 24;
  localparam int ALIEN_PITCH_X = 30;
  localparam int ALIEN_PITCH_Y = 32;
  localparam int ALIEN_X0      = 70;
  localparam int ALIEN_Y0      = 150;

  // Cannon and bullet
  localparam int SHOOTER_Y = 460;  // Top line of the cannon
  localparam int SHOOTER_W = 12;
  localparam int SHOOTER_H = 10;
  localparam int BULLET_W  = 4;
  localparam int BULLET_H  = 8;

  typedef logic [9:0]                   coord_t;
  typedef logic [9:0]                   score_t;
  typedef logic [2:0]                   rgb_t;    // {r, g, b}
  typedef logic [NUM_ROWS*NUM_COLS-1:0] alive_t;  // Row-major
  typedef logic [2:0]                   col_t;

  localparam col_t   START_COL = 3'd2;
  localparam score_t ROW_POINTS [NUM_ROWS] = '{10'd30, 10'd20, 10'd10};

  localparam rgb_t COLOR_ALIEN   = 3'b101;  // Magenta
  localparam rgb_t COLOR_SHOOTER = 3'b011;  // Cyan
  localparam rgb_t COLOR_BULLET  = 3'b111;  // White

  // Screen position of a grid column or row
  function automatic coord_t alien_x(input int col);
    return coord_t'(ALIEN_X0 + col * ALIEN_PITCH_X);
  endfunction

  function automatic coord_t alien_y(input int row);
    return coord_t'(ALIEN_Y0 + row * ALIEN_PITCH_Y);
  endfunction

  // Cannon left edge, centred under its column
  function automatic coord_t shooter_x(input col_t col);
    return coord_t'(ALIEN_X0 + int'(col) * ALIEN_PITCH_X + (ALIEN_W - SHOOTER_W) / 2);
  endfunction

  // Overlap of two rectangles given as corner plus size
  function automatic logic rect_hit(input coord_t ax, input coord_t ay,
                                    input int aw, input int ah,
                                    input coord_t bx, input coord_t by,
                                    input int bw, input int bh);
    return (int'(ax) < int'(bx) + bw) && (int'(bx) < int'(ax) + aw) &&
           (int'(ay) < int'(by) + bh) && (int'(by) < int'(ay) + ah);
  endfunction

endpackage

`default_nettype wire

// File: flist.f
common/invaders_pkg.sv
source/vga_timing.sv
game/shooter_ctrl.sv
game/alien_field.sv
render/sprite_hit.sv
render/color_mix.sv
source/invaders_top.sv
verif/invaders_tb.sv

// File: game/alien_field.sv
`timescale 1ns/1ps
`default_nettype none

module alien_field (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  i_restart,
  input  wire invaders_pkg::coord_t i_bullet_x,
  input  wire invaders_pkg::coord_t i_bullet_y,
  input  wire                  i_bullet_active,
  output invaders_pkg::alive_t o_alive,
  output logic                 o_hit,
  output invaders_pkg::score_t o_score,
  output logic                 o_game_won
);
  import invaders_pkg::*;

  localparam int NUM_ALIENS = NUM_ROWS * NUM_COLS;
  localparam int IDX_W      = $clog2(NUM_ALIENS);

  logic             hit_found;
  logic [IDX_W-1:0] hit_idx;
  score_t           hit_points;
  logic             take_hit;

  // -------------------------------------------------------------------------
  // Bullet against live aliens
  // -------------------------------------------------------------------------
  // Rows are scanned top down, so a later match in a lower row overrides
  always_comb begin
    hit_found  = 1'b0;
    hit_idx    = '0;
    hit_points = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        if (o_alive[r*NUM_COLS + c] &&
            rect_hit(i_bullet_x, i_bullet_y, BULLET_W, BULLET_H,
                     alien_x(c), alien_y(r), ALIEN_W, ALIEN_H)) begin
          hit_found  = 1'b1;
          hit_idx    = IDX_W'(r*NUM_COLS + c);
          hit_points = ROW_POINTS[r];
        end
      end
    end
  end

  // Bullet is still in flight during the o_hit cycle, so ignore it then
  assign take_hit = hit_found && i_bullet_active && !o_hit;

  // -------------------------------------------------------------------------
  // Alive mask and score
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_alive <= '1;
      o_score <= '0;
      o_hit   <= 1'b0;
    end else if (i_restart || o_game_won) begin
      // New round
      o_alive <= '1;
      o_score <= '0;
      o_hit   <= 1'b0;
    end else begin
      o_hit <= take_hit;
      if (take_hit) begin
        o_alive[hit_idx] <= 1'b0;
        o_score          <= o_score + hit_points;
      end
    end
  end

  // Empty grid lasts one cycle before the refill
  assign o_game_won = (o_alive == '0);

  a_hit_needs_bullet: assert property (@(posedge clk) disable iff (!rst_n)
    o_hit |-> i_bullet_active)
    else $error("Alien hit reported with no bullet in flight");

endmodule

`default_nettype wire

// File: game/shooter_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module shooter_ctrl #(
  parameter int BULLET_DIV = 3000
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  i_btn_left,
  input  wire                  i_btn_right,
  input  wire                  i_btn_fire,
  input  wire                  i_restart,
  input  wire                  i_hit,
  output invaders_pkg::col_t   o_col,
  output invaders_pkg::coord_t o_bullet_x,
  output invaders_pkg::coord_t o_bullet_y,
  output logic                 o_bullet_active
);
  import invaders_pkg::*;

  localparam int               DIV_W      = (BULLET_DIV > 1) ? $clog2(BULLET_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST   = DIV_W'(BULLET_DIV - 1);
  localparam coord_t           LAUNCH_Y   = coord_t'(SHOOTER_Y - BULLET_H);
  localparam coord_t           BULLET_OFS = coord_t'((SHOOTER_W - BULLET_W) / 2);

  logic             left_q;
  logic             right_q;
  logic             fire_q;
  logic             left_edge;
  logic             right_edge;
  logic             fire_edge;
  logic [DIV_W-1:0] div_cnt;
  logic             step;

  assign left_edge  = i_btn_left & ~left_q;
  assign right_edge = i_btn_right & ~right_q;
  assign fire_edge  = i_btn_fire & ~fire_q;
  assign step       = (div_cnt == DIV_LAST);  // One pixel up this cycle

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      left_q  <= 1'b0;
      right_q <= 1'b0;
      fire_q  <= 1'b0;
    end else begin
      left_q  <= i_btn_left;
      right_q <= i_btn_right;
      fire_q  <= i_btn_fire;
    end
  end

  // Cannon column, clamped at both edges
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_col <= START_COL;
    end else if (i_restart) begin
      o_col <= START_COL;
    end else if (left_edge && (o_col != '0)) begin
      o_col <= o_col - 1'b1;
    end else if (right_edge && (o_col != col_t'(NUM_COLS - 1))) begin
      o_col <= o_col + 1'b1;
    end
  end

  // -------------------------------------------------------------------------
  // Bullet flight
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_bullet_active <= 1'b0;
      div_cnt         <= '0;
    end else if (i_restart || i_hit) begin
      o_bullet_active <= 1'b0;
      div_cnt         <= '0;
    end else if (!o_bullet_active) begin
      o_bullet_active <= fire_edge;  // Launch
      div_cnt         <= '0;
    end else if (step) begin
      div_cnt <= '0;
      if (o_bullet_y == '0) begin
        o_bullet_active <= 1'b0;  // Left the top of the screen
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!o_bullet_active && fire_edge) begin
      o_bullet_x <= shooter_x(o_col) + BULLET_OFS;
      o_bullet_y <= LAUNCH_Y;
    end else if (o_bullet_active && step && (o_bullet_y != '0)) begin
      o_bullet_y <= o_bullet_y - 1'b1;
    end
  end

  a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
    int'(o_col) < NUM_COLS)
    else $error("Cannon column %0d out of range", o_col);

endmodule

`default_nettype wire

// File: render/color_mix.sv
`timescale 1ns/1ps
`default_nettype none

module color_mix (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                i_alien_px,
  input  wire                i_shooter_px,
  input  wire                i_bullet_px,
  input  wire                i_active,
  input  wire                i_hsync,
  input  wire                i_vsync,
  output invaders_pkg::rgb_t o_rgb,
  output logic               o_hsync,
  output logic               o_vsync
);
  import invaders_pkg::*;

  rgb_t pix_color;

  // Bullet over cannon over alien, black elsewhere
  always_comb begin
    if (!i_active) begin
      pix_color = '0;  // Blanking
    end else if (i_bullet_px) begin
      pix_color = COLOR_BULLET;
    end else if (i_shooter_px) begin
      pix_color = COLOR_SHOOTER;
    end else if (i_alien_px) begin
      pix_color = COLOR_ALIEN;
    end else begin
      pix_color = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rgb   <= '0;
      o_hsync <= 1'b1;
      o_vsync <= 1'b1;
    end else begin
      o_rgb   <= pix_color;
      o_hsync <= i_hsync;
      o_vsync <= i_vsync;
    end
  end

endmodule

`default_nettype wire

// File: render/sprite_hit.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_hit (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire invaders_pkg::coord_t i_x,
  input  wire invaders_pkg::coord_t i_y,
  input  wire                  i_active,
  input  wire                  i_hsync,
  input  wire                  i_vsync,
  input  wire invaders_pkg::alive_t i_alive,
  input  wire invaders_pkg::col_t   i_col,
  input  wire invaders_pkg::coord_t i_bullet_x,
  input  wire invaders_pkg::coord_t i_bullet_y,
  input  wire                  i_bullet_active,
  output logic                 o_alien_px,
  output logic                 o_shooter_px,
  output logic                 o_bullet_px,
  output logic                 o_active,
  output logic                 o_hsync,
  output logic                 o_vsync
);
  import invaders_pkg::*;

  logic alien_px;
  logic shooter_px;
  logic bullet_px;

  // Any live alien under the current pixel
  always_comb begin
    alien_px = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        if (i_alive[r*NUM_COLS + c] &&
            rect_hit(i_x, i_y, 1, 1, alien_x(c), alien_y(r), ALIEN_W, ALIEN_H)) begin
          alien_px = 1'b1;
        end
      end
    end
  end

  assign shooter_px = rect_hit(i_x, i_y, 1, 1, shooter_x(i_col), coord_t'(SHOOTER_Y),
                               SHOOTER_W, SHOOTER_H);
  assign bullet_px  = i_bullet_active &&
                      rect_hit(i_x, i_y, 1, 1, i_bullet_x, i_bullet_y, BULLET_W, BULLET_H);

  // -------------------------------------------------------------------------
  // Stage 1 register, flags travel with their sync and blanking
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_alien_px   <= 1'b0;
      o_shooter_px <= 1'b0;
      o_bullet_px  <= 1'b0;
      o_active     <= 1'b0;
      o_hsync      <= 1'b1;  // Idle high
      o_vsync      <= 1'b1;
    end else begin
      o_alien_px   <= alien_px;
      o_shooter_px <= shooter_px;
      o_bullet_px  <= bullet_px;
      o_active     <= i_active;
      o_hsync      <= i_hsync;
      o_vsync      <= i_vsync;
    end
  end

endmodule

`default_nettype wire

// File: source/invaders_top.sv
`timescale 1ns/1ps
`default_nettype none

module invaders_top #(
  parameter int BULLET_DIV = 3000
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  i_btn_left,
  input  wire                  i_btn_right,
  input  wire                  i_btn_fire,
  input  wire                  i_restart,
  output logic                 o_hsync,
  output logic                 o_vsync,
  output invaders_pkg::rgb_t   o_rgb,
  output invaders_pkg::score_t o_score,
  output logic                 o_game_won
);
  import invaders_pkg::*;

  // Stage 0, raw scan position
  coord_t pix_x;
  coord_t pix_y;
  logic   pix_active;
  logic   raw_hsync;
  logic   raw_vsync;

  // Game state
  col_t   col;
  coord_t bullet_x;
  coord_t bullet_y;
  logic   bullet_active;
  logic   hit;
  alive_t alive;

  // Stage 1, registered hit flags
  logic   s1_alien_px;
  logic   s1_shooter_px;
  logic   s1_bullet_px;
  logic   s1_active;
  logic   s1_hsync;
  logic   s1_vsync;

  vga_timing u_vga_timing (
    .clk      (clk),
    .rst_n    (rst_n),
    .o_x      (pix_x),
    .o_y      (pix_y),
    .o_active (pix_active),
    .o_hsync  (raw_hsync),
    .o_vsync  (raw_vsync)
  );

  shooter_ctrl #(
    .BULLET_DIV (BULLET_DIV)
  ) u_shooter_ctrl (
    .clk (clk), .rst_n (rst_n),
    .i_btn_left (i_btn_left), .i_btn_right (i_btn_right), .i_btn_fire (i_btn_fire),
    .i_restart (i_restart), .i_hit (hit),
    .o_col (col), .o_bullet_x (bullet_x), .o_bullet_y (bullet_y),
    .o_bullet_active (bullet_active)
  );

  alien_field u_alien_field (
    .clk (clk), .rst_n (rst_n), .i_restart (i_restart),
    .i_bullet_x (bullet_x), .i_bullet_y (bullet_y), .i_bullet_active (bullet_active),
    .o_alive (alive), .o_hit (hit), .o_score (o_score), .o_game_won (o_game_won)
  );

  sprite_hit u_sprite_hit (
    .clk (clk), .rst_n (rst_n),
    .i_x (pix_x), .i_y (pix_y), .i_active (pix_active),
    .i_hsync (raw_hsync), .i_vsync (raw_vsync),
    .i_alive (alive), .i_col (col),
    .i_bullet_x (bullet_x), .i_bullet_y (bullet_y), .i_bullet_active (bullet_active),
    .o_alien_px (s1_alien_px), .o_shooter_px (s1_shooter_px), .o_bullet_px (s1_bullet_px),
    .o_active (s1_active), .o_hsync (s1_hsync), .o_vsync (s1_vsync)
  );

  color_mix u_color_mix (
    .clk (clk), .rst_n (rst_n),
    .i_alien_px (s1_alien_px), .i_shooter_px (s1_shooter_px), .i_bullet_px (s1_bullet_px),
    .i_active (s1_active), .i_hsync (s1_hsync), .i_vsync (s1_vsync),
    .o_rgb (o_rgb), .o_hsync (o_hsync), .o_vsync (o_vsync)
  );

endmodule

`default_nettype wire

// File: source/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
  input  wire                  clk,
  input  wire                  rst_n,
  output invaders_pkg::coord_t o_x,
  output invaders_pkg::coord_t o_y,
  output logic                 o_active,
  output logic                 o_hsync,
  output logic                 o_vsync
);
  import invaders_pkg::*;

  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  coord_t h_cnt;
  coord_t v_cnt;
  logic   h_last;
  logic   v_last;

  assign h_last = (h_cnt == coord_t'(H_TOTAL - 1));
  assign v_last = (v_cnt == coord_t'(V_TOTAL - 1));

  // -------------------------------------------------------------------------
  // Pixel and line counters
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
      if (v_last) begin
        v_cnt <= '0;  // New frame
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign o_x = h_cnt;
  assign o_y = v_cnt;

  // Sync pulses are active low
  assign o_hsync = !((h_cnt >= coord_t'(H_SYNC_START)) && (h_cnt < coord_t'(H_SYNC_END)));
  assign o_vsync = !((v_cnt >= coord_t'(V_SYNC_START)) && (v_cnt < coord_t'(V_SYNC_END)));
  assign o_active = (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));

  a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
    (int'(h_cnt) < H_TOTAL) && (int'(v_cnt) < V_TOTAL))
    else $error("VGA counter out of range h=%0d v=%0d", h_cnt, v_cnt);

endmodule

`default_nettype wire

// File: verif/invaders_tb.sv
`timescale 1ns/1ps
`default_nettype none

module invaders_tb;
  import invaders_pkg::*;

  localparam int DIV          = 4;
  localparam int BULLET_BOUND = SHOOTER_Y * DIV + 4;  // Longest bullet flight
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int ALIEN_AREA   = 24 * 24;
  localparam int SHOOTER_AREA = 12 * 10;
  localparam int FULL_SCORE   = NUM_COLS * (30 + 20 + 10);
  localparam logic [2:0] MAGENTA = 3'b101;
  localparam logic [2:0] CYAN    = 3'b011;

  logic       clk;
  logic       rst_n;
  logic       btn_left;
  logic       btn_right;
  logic       btn_fire;
  logic       restart;
  logic       hsync;
  logic       vsync;
  rgb_t       rgb;
  score_t     score;
  logic       game_won;

  // Vector queues, one entry per command line
  byte        cmd_q[$];
  int         score_q[$];
  int         live_q[$];
  int         cycle_limit = 0;

  // Monitor state, sampled on the falling edge
  logic       prev_hs;
  logic       prev_vs;
  logic       h_lock;
  logic       v_lock;
  int         px;
  int         py;
  int         hs_low;
  int         vs_low;
  int         hs_gap;
  logic       frame_req = 1'b0;
  logic       frame_done = 1'b0;
  logic       counting;
  int         magenta_cnt;
  int         cyan_cnt;
  int         cyan_left;
  int         win_cnt;
  int         win_score;

  invaders_top #(
    .BULLET_DIV (DIV)
  ) uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_btn_left  (btn_left),
    .i_btn_right (btn_right),
    .i_btn_fire  (btn_fire),
    .i_restart   (restart),
    .o_hsync     (hsync),
    .o_vsync     (vsync),
    .o_rgb       (rgb),
    .o_score     (score),
    .o_game_won  (game_won)
  );

  always #2 clk = ~clk;

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("FAILED %s expected %0d actual %0d", name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  // Button held two cycles, so only one edge reaches the DUT
  task automatic press_button(input byte cmd);
    @(negedge clk);
    case (cmd)
      "L":     btn_left = 1'b1;
      "R":     btn_right = 1'b1;
      "F":     btn_fire = 1'b1;
      default: restart = 1'b1;
    endcase
    repeat (2) @(negedge clk);
    btn_left  = 1'b0;
    btn_right = 1'b0;
    btn_fire  = 1'b0;
    restart   = 1'b0;
    @(negedge clk);
  endtask

  task automatic count_frame();
    frame_req = 1'b1;  // Counting starts at the next vsync
    wait (frame_done);
    frame_done = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Sync timing, blanking and pixel counting from the output stream
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    if (!rst_n) begin
      prev_hs  = 1'b1;
      prev_vs  = 1'b1;
      h_lock   = 1'b0;
      v_lock   = 1'b0;
      hs_low   = 0;
      vs_low   = 0;
      hs_gap   = 0;
      counting = 1'b0;
      win_cnt  = 0;
    end else begin
      hs_gap = hs_gap + 1;
      if (!hsync) hs_low = hs_low + 1;
      if (!vsync) vs_low = vs_low + 1;
      if (!prev_hs && hsync) begin
        check_value("hsync low cycles", H_SYNC, hs_low);
        hs_low = 0;
      end
      if (!prev_vs && vsync) begin
        check_value("vsync low cycles", V_SYNC * H_TOTAL, vs_low);
        vs_low = 0;
      end
      // Scan position rebuilt from the syncs
      if (prev_hs && !hsync) begin
        if (h_lock) check_value("hsync period", H_TOTAL, hs_gap);
        hs_gap = 0;
        h_lock = 1'b1;
        px     = H_ACTIVE + H_FRONT;
      end else if (px == H_TOTAL - 1) begin
        px = 0;
        py = (py == V_TOTAL - 1) ? 0 : py + 1;
      end else begin
        px = px + 1;
      end
      if (prev_vs && !vsync) begin
        py     = V_ACTIVE + V_FRONT;
        v_lock = 1'b1;
        if (counting) begin
          counting   = 1'b0;
          frame_done = 1'b1;
        end else if (frame_req) begin
          frame_req   = 1'b0;
          counting    = 1'b1;
          magenta_cnt = 0;
          cyan_cnt    = 0;
          cyan_left   = H_TOTAL;
        end
      end
      if (h_lock && v_lock && !(px < H_ACTIVE && py < V_ACTIVE)) begin
        check_value("rgb in blanking", 0, int'(rgb));
      end
      if (counting && px < H_ACTIVE && py < V_ACTIVE) begin
        if (rgb == MAGENTA) magenta_cnt = magenta_cnt + 1;
        if (rgb == CYAN) begin
          cyan_cnt = cyan_cnt + 1;
          if (px < cyan_left) cyan_left = px;  // Cannon left edge on screen
        end
      end
      if (game_won) begin
        win_cnt   = win_cnt + 1;
        win_score = int'(score);
      end
      prev_hs = hsync;
      prev_vs = vsync;
    end
  end

  // Run limit from the number of commands
  initial begin
    int cycles;
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("*** TEST FAILED ***");
    $fatal(1, "Timeout");
  end

  initial begin
    int    fd;
    int    sc;
    int    lv;
    int    exp_col;
    byte   c;
    string line;
    string tag;
    clk       = 1'b0;
    rst_n     = 1'b0;
    btn_left  = 1'b0;
    btn_right = 1'b0;
    btn_fire  = 1'b0;
    restart   = 1'b0;
    exp_col   = START_COL;
    fd = $fopen("verif/invaders_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vectors file verif/invaders_vectors.txt");
      $display("*** TEST FAILED ***");
      $fatal(1, "No vectors");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
        if ($sscanf(line, "%c %d %d", c, sc, lv) == 3) begin
          cmd_q.push_back(c);
          score_q.push_back(sc);
          live_q.push_back(lv);
        end
      end
    end
    $fclose(fd);
    if (cmd_q.size() == 0) begin
      $display("The vectors file holds no commands");
      $display("*** TEST FAILED ***");
      $fatal(1, "Empty vectors");
    end
    cycle_limit = cmd_q.size() * (BULLET_BOUND + 2 * FRAME_CYCLES);

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < cmd_q.size(); i++) begin
      tag = $sformatf("step %0d cmd %c", i, cmd_q[i]);
      // Expected cannon column, clamped at both edges
      if (cmd_q[i] == "L" && exp_col > 0) exp_col = exp_col - 1;
      if (cmd_q[i] == "R" && exp_col < NUM_COLS - 1) exp_col = exp_col + 1;
      if (cmd_q[i] == "X") exp_col = START_COL;
      case (cmd_q[i])
        "L", "R", "X": press_button(cmd_q[i]);
        "F": begin
          press_button(cmd_q[i]);
          repeat (BULLET_BOUND) @(negedge clk);  // Hit or miss settles by now
        end
        "C": begin
          count_frame();
          check_value({tag, " alien pixels"}, live_q[i] * ALIEN_AREA, magenta_cnt);
          check_value({tag, " cannon pixels"}, SHOOTER_AREA, cyan_cnt);
          check_value({tag, " cannon left edge"},
                      ALIEN_X0 + exp_col * ALIEN_PITCH_X + 6, cyan_left);
        end
        default: begin
          $display("Unknown command %c in the vectors file", cmd_q[i]);
          $display("*** TEST FAILED ***");
          $fatal(1, "Bad vector");
        end
      endcase
      check_value({tag, " score"}, score_q[i], int'(score));
      check_value({tag, " live aliens"}, live_q[i], $countones(uut.alive));
    end

    check_value("round win pulses", 1, win_cnt);
    check_value("score at round win", FULL_SCORE, win_score);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/invaders_vectors.txt
# cmd expected_score expected_live_aliens
# L/R move cannon, F fire, X restart, C count one frame of alien pixels
F 10 17
F 30 16
F 60 15
F 60 15
X 0 18
F 10 17
F 30 16
F 60 15
L 60 15
F 70 14
F 90 13
F 120 12
L 120 12
L 120 12
F 130 11
F 150 10
F 180 9
C 180 9
R 180 9
R 180 9
R 180 9
F 190 8
F 210 7
F 240 6
R 240 6
F 250 5
F 270 4
F 300 3
R 300 3
R 300 3
F 310 2
F 330 1
F 0 18
C 0 18
